/* Makefile */
# Verilator simulation of the single-cycle MIPS core.

VERILATOR ?= verilator
TOP       ?= mipsCoreTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
+incdir+include
source/mipsPkg.sv
source/instrRom.sv
source/controlGen.sv
source/aluDatapath.sv
source/pcDatapath.sv
source/registerDatapath.sv
source/dataMemory.sv
source/mipsCore.sv
verif/mipsCoreTb.sv

/* include/mips_config.svh */
`ifndef MIPS_CONFIG_SVH
`define MIPS_CONFIG_SVH

// ####################
// core sizes.
// ####################

// data and instruction word width in bits.
`define MIPS_WORD_W 32

// instruction words held by the ROM.
`define MIPS_ROM_DEPTH 64

// data words held by the RAM.
`define MIPS_RAM_DEPTH 128

// architectural registers, r0 included.
`define MIPS_REG_COUNT 32

`endif

/* source/aluDatapath.sv */
`timescale 1ns/100ps
`default_nettype none

module aluDatapath (
	input  wire logic [$bits(mipsPkg::aluOp_t):0] control,
	input  wire mipsPkg::word_t                   regPort1,
	input  wire mipsPkg::word_t                   regPort2,
	input  wire mipsPkg::word_t                   instruction,
	output mipsPkg::word_t                        result,
	output logic                                  zero
);
	import mipsPkg::*;

	aluOp_t aluOp;
	logic   aluSrcImm;
	word_t  immExt;
	word_t  operandB;
	logic   lessThan;

	// ####################
	// operand select.
	// ####################
	assign aluOp     = aluOp_t'(control[$bits(aluOp_t):1]);
	assign aluSrcImm = control[0];

	assign immExt   = {{16{instruction[15]}}, instruction[15:0]};
	assign operandB = aluSrcImm ? immExt : regPort2;

	// ####################
	// compute.
	// ####################

	// slt compares as two's complement.
	assign lessThan = $signed(regPort1) < $signed(operandB);

	always_comb begin
		case (aluOp)
			aluAdd: result = regPort1 + operandB;
			aluSub: result = regPort1 - operandB;
			aluAnd: result = regPort1 & operandB;
			aluOr: result = regPort1 | operandB;
			aluSlt: result = word_t'(lessThan);
			default: result = regPort1 + operandB;
		endcase
	end

	// beq relies on this after a subtract.
	assign zero = (result == '0);

endmodule

`default_nettype wire

/* source/controlGen.sv */
`timescale 1ns/100ps
`default_nettype none

module controlGen (
	input  wire mipsPkg::word_t instruction,
	output mipsPkg::control_t   control
);
	import mipsPkg::*;

	opcode_t opcode;
	funct_t  funct;

	assign opcode = opcode_t'(instruction[31:26]);
	assign funct  = funct_t'(instruction[5:0]);

	always_comb begin
		// no-op unless the decode below says otherwise.
		control.aluOp     = aluAdd;
		control.aluSrcImm = 1'b0;
		control.memWrite  = 1'b0;
		control.memRead   = 1'b0;
		control.regWrite  = 1'b0;
		control.regDst    = dstRt;
		control.regWrSel  = wrAlu;
		control.pcSel     = pcSeq;

		case (opcode)
			opRType: begin
				control.regDst = dstRd;
				case (funct)
					fnAdd: begin
						control.aluOp    = aluAdd;
						control.regWrite = 1'b1;
					end
					fnSub: begin
						control.aluOp    = aluSub;
						control.regWrite = 1'b1;
					end
					fnAnd: begin
						control.aluOp    = aluAnd;
						control.regWrite = 1'b1;
					end
					fnOr: begin
						control.aluOp    = aluOr;
						control.regWrite = 1'b1;
					end
					fnSlt: begin
						control.aluOp    = aluSlt;
						control.regWrite = 1'b1;
					end
					fnJr: control.pcSel = pcReg;
					default: ;
				endcase
			end
			opAddi: begin
				control.aluSrcImm = 1'b1;
				control.regWrite  = 1'b1;
			end
			opLw: begin
				control.aluSrcImm = 1'b1;
				control.memRead   = 1'b1;
				control.regWrite  = 1'b1;
				control.regWrSel  = wrMem;
			end
			opSw: begin
				control.aluSrcImm = 1'b1;
				control.memWrite  = 1'b1;
			end
			opBeq: begin
				// equality is tested through the zero flag of a subtract.
				control.aluOp = aluSub;
				control.pcSel = pcBranch;
			end
			opJ: control.pcSel = pcJump;
			opJal: begin
				control.pcSel    = pcJump;
				control.regWrite = 1'b1;
				control.regDst   = dstRa;
				control.regWrSel = wrRet;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* source/dataMemory.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_config.svh"

module dataMemory (
	input  wire                    clk,
	input  wire                    memWrite,
	input  wire mipsPkg::ramAddr_t addr,
	input  wire mipsPkg::word_t    data,
	output mipsPkg::word_t         out
);
	import mipsPkg::*;

	word_t ram [`MIPS_RAM_DEPTH];

	// ####################
	// store port.
	// ####################

	// the store lands on the same edge that retires the sw.
	always_ff @(posedge clk) begin
		if (memWrite) begin
			ram[addr] <= data;
		end
	end

	// ####################
	// load port.
	// ####################

	// lw sees the word within the cycle, ready for the register write.
	assign out = ram[addr];

endmodule

`default_nettype wire

/* source/instrRom.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_config.svh"

module instrRom (
	input  wire                     clk,
	input  wire                     arstN,
	input  wire mipsPkg::progLoad_t progLoad,
	input  wire mipsPkg::romAddr_t  addr,
	output mipsPkg::word_t          instruction
);
	import mipsPkg::*;

	word_t rom [`MIPS_ROM_DEPTH];

	// the program is written only while the core sits in reset.
	always_ff @(posedge clk) begin
		if (!arstN && progLoad.we) begin
			rom[progLoad.addr] <= progLoad.data;
		end
	end

	// a zero word decodes as a no-op while the program loads.
	assign instruction = arstN ? rom[addr] : '0;

	aLoadInReset: assert property (@(posedge clk) arstN |-> !progLoad.we)
		else $error("program load strobe seen while the core runs");

endmodule

`default_nettype wire

/* source/mipsCore.sv */
`timescale 1ns/100ps
`default_nettype none

module mipsCore (
	input  wire                     clk,
	input  wire                     arstN,
	input  wire mipsPkg::progLoad_t progLoad,
	output mipsPkg::word_t          pcAddr,
	output mipsPkg::storeObs_t      storeObs
);
	import mipsPkg::*;

	word_t    instruction;
	control_t control;
	word_t    regPort1;
	word_t    regPort2;
	word_t    aluResult;
	logic     aluZero;
	word_t    pcCurr;
	word_t    returnAddr;
	word_t    ramOut;
	romAddr_t romAddr;
	ramAddr_t ramAddr;

	// byte addresses to word indices.
	assign romAddr = pcCurr[7:2];
	assign ramAddr = aluResult[8:2];

	instrRom rom0 (.clk(clk), .arstN(arstN), .progLoad(progLoad), .addr(romAddr),
		.instruction(instruction));

	controlGen ctrlGen0 (.instruction(instruction), .control(control));

	aluDatapath alu0 (.control({control.aluOp, control.aluSrcImm}), .regPort1(regPort1),
		.regPort2(regPort2), .instruction(instruction), .result(aluResult), .zero(aluZero));

	pcDatapath pc0 (.clk(clk), .arstN(arstN), .pcSel(control.pcSel), .zero(aluZero),
		.instruction(instruction), .regPort1(regPort1), .addrCurr(pcCurr),
		.returnAddr(returnAddr));

	registerDatapath reg0 (.clk(clk), .arstN(arstN), .regWrite(control.regWrite),
		.regDst(control.regDst), .regWrSel(control.regWrSel), .instruction(instruction),
		.aluResult(aluResult), .ramOut(ramOut), .returnAddr(returnAddr), .port1(regPort1),
		.port2(regPort2));

	dataMemory ram0 (.clk(clk), .memWrite(control.memWrite), .addr(ramAddr),
		.data(regPort2), .out(ramOut));

	// ####################
	// observation.
	// ####################
	assign pcAddr         = pcCurr;
	assign storeObs.valid = control.memWrite;
	assign storeObs.addr  = ramAddr;
	assign storeObs.data  = regPort2;

endmodule

`default_nettype wire

/* source/mipsPkg.sv */
`default_nettype none

`include "mips_config.svh"

package mipsPkg;

	// ####################
	// widths.
	// ####################
	typedef logic [`MIPS_WORD_W-1:0] word_t;
	typedef logic [$clog2(`MIPS_REG_COUNT)-1:0] regAddr_t;
	typedef logic [$clog2(`MIPS_ROM_DEPTH)-1:0] romAddr_t;
	typedef logic [$clog2(`MIPS_RAM_DEPTH)-1:0] ramAddr_t;

	// ####################
	// encodings.
	// ####################
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opJ     = 6'h02,
		opJal   = 6'h03,
		opBeq   = 6'h04,
		opAddi  = 6'h08,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcode_t;

	typedef enum logic [5:0] {
		fnJr  = 6'h08,
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnSlt = 6'h2a
	} funct_t;

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOp_t;
	typedef enum logic [1:0] {pcSeq, pcBranch, pcJump, pcReg} pcSel_t;
	typedef enum logic [1:0] {wrAlu, wrMem, wrRet} regWrSel_t;
	typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDstSel_t;

	// ####################
	// bundles.
	// ####################

	// aluOp and aluSrcImm sit on top so the ALU takes them as one slice.
	typedef struct packed {
		aluOp_t     aluOp;
		logic       aluSrcImm;
		logic       memWrite;
		logic       memRead;
		logic       regWrite;
		regDstSel_t regDst;
		regWrSel_t  regWrSel;
		pcSel_t     pcSel;
	} control_t;

	typedef struct packed {
		logic     we;
		romAddr_t addr;
		word_t    data;
	} progLoad_t;

	typedef struct packed {
		logic     valid;
		ramAddr_t addr;
		word_t    data;
	} storeObs_t;

endpackage

`default_nettype wire

/* source/pcDatapath.sv */
`timescale 1ns/100ps
`default_nettype none

module pcDatapath (
	input  wire                  clk,
	input  wire                  arstN,
	input  wire mipsPkg::pcSel_t pcSel,
	input  wire                  zero,
	input  wire mipsPkg::word_t  instruction,
	input  wire mipsPkg::word_t  regPort1,
	output mipsPkg::word_t       addrCurr,
	output mipsPkg::word_t       returnAddr
);
	import mipsPkg::*;

	word_t pcPlus4;
	word_t branchTarget;
	word_t jumpTarget;
	word_t addrNext;

	// ####################
	// next address.
	// ####################
	assign pcPlus4      = addrCurr + word_t'(4);
	assign branchTarget = pcPlus4 + {{14{instruction[15]}}, instruction[15:0], 2'b00};
	assign jumpTarget   = {pcPlus4[31:28], instruction[25:0], 2'b00};

	// jal links to the instruction after itself.
	assign returnAddr = pcPlus4;

	always_comb begin
		case (pcSel)
			pcSeq: addrNext = pcPlus4;
			pcBranch: addrNext = zero ? branchTarget : pcPlus4;
			pcJump: addrNext = jumpTarget;
			pcReg: addrNext = regPort1;
			default: addrNext = pcPlus4;
		endcase
	end

	// ####################
	// pc register.
	// ####################
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			addrCurr <= '0;
		end else begin
			addrCurr <= addrNext;
		end
	end

	aPcAligned: assert property (@(posedge clk) disable iff (!arstN) addrCurr[1:0] == 2'b00)
		else $error("pc left word alignment");

endmodule

`default_nettype wire

/* source/registerDatapath.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_config.svh"

module registerDatapath (
	input  wire                      clk,
	input  wire                      arstN,
	input  wire                      regWrite,
	input  wire mipsPkg::regDstSel_t regDst,
	input  wire mipsPkg::regWrSel_t  regWrSel,
	input  wire mipsPkg::word_t      instruction,
	input  wire mipsPkg::word_t      aluResult,
	input  wire mipsPkg::word_t      ramOut,
	input  wire mipsPkg::word_t      returnAddr,
	output mipsPkg::word_t           port1,
	output mipsPkg::word_t           port2
);
	import mipsPkg::*;

	word_t    regs [`MIPS_REG_COUNT];
	regAddr_t rs;
	regAddr_t rt;
	regAddr_t rd;
	regAddr_t wrAddr;
	word_t    wrData;

	assign rs = instruction[25:21];
	assign rt = instruction[20:16];
	assign rd = instruction[15:11];

	// r0 is cleared by reset and never written.
	assign port1 = regs[rs];
	assign port2 = regs[rt];

	always_comb begin
		case (regDst)
			dstRd: wrAddr = rd;
			dstRa: wrAddr = regAddr_t'(31);
			default: wrAddr = rt;
		endcase

		case (regWrSel)
			wrMem: wrData = ramOut;
			wrRet: wrData = returnAddr;
			default: wrData = aluResult;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	aZeroReg: assert property (@(posedge clk) disable iff (!arstN) (rs == '0) |-> (port1 == '0))
		else $error("r0 read back nonzero");

endmodule

`default_nettype wire

/* verif/mipsCoreTb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mips_config.svh"

module mipsCoreTb;
	import mipsPkg::*;

	localparam int ClkPeriod = 4;
	localparam int CycleLimit = 64;
	localparam int NumTests = 6;
	localparam int WatchdogNs = NumTests * (CycleLimit + `MIPS_ROM_DEPTH + 8) * ClkPeriod;

	// ####################
	// MIPS encodings.
	// ####################
	localparam logic [5:0] OpRType = 6'h00;
	localparam logic [5:0] OpJ = 6'h02;
	localparam logic [5:0] OpJal = 6'h03;
	localparam logic [5:0] OpBeq = 6'h04;
	localparam logic [5:0] OpAddi = 6'h08;
	localparam logic [5:0] OpLw = 6'h23;
	localparam logic [5:0] OpSw = 6'h2b;
	localparam logic [5:0] FnJr = 6'h08;
	localparam logic [5:0] FnAdd = 6'h20;
	localparam logic [5:0] FnSub = 6'h22;
	localparam logic [5:0] FnAnd = 6'h24;
	localparam logic [5:0] FnOr = 6'h25;
	localparam logic [5:0] FnSlt = 6'h2a;

	logic      clk;
	logic      arstN;
	progLoad_t progLoad;
	word_t     pcAddr;
	storeObs_t storeObs;
	int        errors;
	int        checks;
	word_t     prog[$];
	word_t     obsData[$];
	word_t     modelRegs[`MIPS_REG_COUNT];
	word_t     modelMem[`MIPS_RAM_DEPTH];

	mipsCore dut0 (.clk(clk), .arstN(arstN), .progLoad(progLoad), .pcAddr(pcAddr),
		.storeObs(storeObs));

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	initial begin
		#(WatchdogNs);
		$display("timeout: the tests did not finish in the expected time");
		$display("Done: errors found");
		$finish;
	end

	function automatic word_t rType(input logic [5:0] funct, input int rs, input int rt,
		input int rd);
		return {OpRType, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
	endfunction

	function automatic word_t iType(input logic [5:0] op, input int rs, input int rt,
		input int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	function automatic word_t jType(input logic [5:0] op, input int index);
		return {op, 26'(index)};
	endfunction

	task automatic finishProgram();
		prog.push_back(jType(OpJ, prog.size()));
	endtask

	task automatic checkValue(input string name, input word_t got, input word_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAIL %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// ####################
	// reference model.
	// ####################
	task automatic writeReg(input regAddr_t idx, input word_t value);
		if (idx != 5'd0) begin
			modelRegs[idx] = value;
		end
	endtask

	task automatic modelStep(input word_t pc, output word_t next, output logic st,
		output ramAddr_t stAddr, output word_t stData);
		word_t inst;
		word_t a;
		word_t b;
		word_t imm;
		word_t ea;
		word_t pcp4;
		inst = prog[pc[7:2]];
		a = modelRegs[inst[25:21]];
		b = modelRegs[inst[20:16]];
		imm = {{16{inst[15]}}, inst[15:0]};
		ea = a + imm;
		pcp4 = pc + 32'd4;
		next = pcp4;
		st = 1'b0;
		stAddr = '0;
		stData = '0;
		case (inst[31:26])
			OpRType: begin
				case (inst[5:0])
					FnAdd: writeReg(inst[15:11], a + b);
					FnSub: writeReg(inst[15:11], a - b);
					FnAnd: writeReg(inst[15:11], a & b);
					FnOr: writeReg(inst[15:11], a | b);
					FnSlt: writeReg(inst[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
					FnJr: next = a;
					default: ;
				endcase
			end
			OpAddi: writeReg(inst[20:16], ea);
			OpLw: writeReg(inst[20:16], modelMem[ea[8:2]]);
			OpSw: begin
				st = 1'b1;
				stAddr = ea[8:2];
				stData = b;
				modelMem[stAddr] = b;
			end
			OpBeq: if (a == b) next = pcp4 + (imm << 2);
			OpJ: next = {pcp4[31:28], inst[25:0], 2'b00};
			OpJal: begin
				writeReg(5'd31, pcp4);
				next = {pcp4[31:28], inst[25:0], 2'b00};
			end
			default: ;
		endcase
	endtask

	// ####################
	// load and run.
	// ####################
	task automatic loadProgram();
		int loadCycles;
		@(posedge clk);
		arstN <= 1'b0;
		for (int i = 0; i < prog.size(); i++) begin
			@(posedge clk);
			progLoad <= {1'b1, romAddr_t'(i), prog[i]};
		end
		@(posedge clk);
		progLoad <= '0;
		loadCycles = prog.size() + 1;
		while (loadCycles < 5) begin
			@(posedge clk);
			loadCycles++;
		end
		@(negedge clk);
		checkValue("pcAddr", pcAddr, '0);
		checkValue("storeObs.valid", word_t'(storeObs.valid), '0);
		@(posedge clk);
		arstN <= 1'b1;
	endtask

	// lock step against the model until the final self-jump.
	task automatic runProgram(input string name);
		word_t    pc;
		word_t    next;
		logic     st;
		ramAddr_t stAddr;
		word_t    stData;
		logic     done;
		obsData.delete();
		loadProgram();
		for (int i = 0; i < `MIPS_REG_COUNT; i++) begin
			modelRegs[i] = '0;
		end
		pc = '0;
		done = 1'b0;
		for (int cyc = 0; cyc < CycleLimit && !done; cyc++) begin
			@(negedge clk);
			modelStep(pc, next, st, stAddr, stData);
			checkValue("pcAddr", pcAddr, pc);
			checkValue("storeObs.valid", word_t'(storeObs.valid), word_t'(st));
			if (st) begin
				checkValue("storeObs.addr", word_t'(storeObs.addr), word_t'(stAddr));
				checkValue("storeObs.data", storeObs.data, stData);
				obsData.push_back(storeObs.data);
			end
			done = (next == pc);
			pc = next;
		end
		checks++;
		assert (done) else begin
			errors++;
			$display("%s: program did not reach its final jump in %0d cycles", name, CycleLimit);
		end
	endtask

	// ####################
	// directed tests.
	// ####################
	task automatic straightLinePc();
		prog.delete();
		prog.push_back(iType(OpAddi, 0, 1, 1));
		prog.push_back(iType(OpAddi, 1, 2, 2));
		prog.push_back(32'h0);
		prog.push_back(iType(OpAddi, 2, 3, 3));
		prog.push_back(rType(FnAdd, 1, 2, 4));
		finishProgram();
		runProgram("straight line");
	endtask

	task automatic aluOpStores();
		prog.delete();
		prog.push_back(iType(OpAddi, 0, 1, 7));
		prog.push_back(iType(OpAddi, 0, 2, -5));
		prog.push_back(iType(OpAddi, 0, 9, 12));
		prog.push_back(rType(FnAdd, 1, 2, 3));
		prog.push_back(iType(OpSw, 0, 3, 0));
		prog.push_back(rType(FnSub, 2, 1, 4));
		prog.push_back(iType(OpSw, 0, 4, 4));
		prog.push_back(rType(FnAnd, 1, 9, 5));
		prog.push_back(iType(OpSw, 0, 5, 8));
		prog.push_back(rType(FnOr, 1, 9, 6));
		prog.push_back(iType(OpSw, 0, 6, 12));
		// negative against positive, both ways.
		prog.push_back(rType(FnSlt, 2, 1, 7));
		prog.push_back(iType(OpSw, 0, 7, 16));
		prog.push_back(rType(FnSlt, 1, 2, 8));
		prog.push_back(iType(OpSw, 0, 8, 20));
		finishProgram();
		runProgram("alu ops");
	endtask

	task automatic loadStoreRoundTrip();
		prog.delete();
		prog.push_back(iType(OpAddi, 0, 1, 16'h1234));
		prog.push_back(iType(OpSw, 0, 1, 64));
		prog.push_back(iType(OpLw, 0, 2, 64));
		prog.push_back(iType(OpSw, 0, 2, 68));
		finishProgram();
		runProgram("load store");
		checkValue("store count", word_t'(obsData.size()), 32'd2);
		if (obsData.size() == 2) checkValue("reloaded data", obsData[1], 32'h1234);
	endtask

	task automatic branchSkip();
		prog.delete();
		prog.push_back(iType(OpAddi, 0, 1, 3));
		prog.push_back(iType(OpAddi, 0, 2, 3));
		prog.push_back(iType(OpBeq, 1, 2, 1));
		prog.push_back(iType(OpSw, 0, 1, 32));
		prog.push_back(iType(OpSw, 0, 1, 36));
		prog.push_back(iType(OpBeq, 1, 0, 1));
		prog.push_back(iType(OpSw, 0, 2, 40));
		prog.push_back(iType(OpSw, 0, 2, 44));
		finishProgram();
		runProgram("branch");
		checkValue("store count", word_t'(obsData.size()), 32'd3);
	endtask

	task automatic callReturn();
		prog.delete();
		prog.push_back(iType(OpAddi, 0, 1, 9));
		prog.push_back(jType(OpJal, 4));
		prog.push_back(iType(OpSw, 0, 1, 48));
		finishProgram();
		// subroutine at word 4.
		prog.push_back(iType(OpSw, 0, 31, 52));
		prog.push_back(rType(FnJr, 31, 0, 0));
		runProgram("call return");
		checkValue("store count", word_t'(obsData.size()), 32'd2);
		if (obsData.size() == 2) checkValue("return address", obsData[0], 32'd8);
	endtask

	task automatic zeroRegister();
		prog.delete();
		prog.push_back(iType(OpAddi, 0, 0, 5));
		prog.push_back(iType(OpAddi, 0, 1, 3));
		prog.push_back(rType(FnAdd, 1, 1, 0));
		prog.push_back(iType(OpSw, 0, 0, 56));
		finishProgram();
		runProgram("zero register");
		if (obsData.size() == 1) checkValue("r0 store", obsData[0], '0);
	endtask

	initial begin
		arstN = 1'b0;
		progLoad = '0;
		errors = 0;
		checks = 0;
		straightLinePc();
		aluOpStores();
		loadStoreRoundTrip();
		branchSkip();
		callReturn();
		zeroRegister();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) $display("Done: no errors");
		else $display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire
